/* rtl/l2_geom_pkg.sv */
// geometry of a 4-way, 16-set L2 with lines of 4 words of 64 bits
// byte addresses are 32 bits wide, and there is no physical address extension
// each width must be changed along with the count it belongs to
`default_nettype none

package l2_geom_pkg;

  // ========================================
  // sizes
  // ========================================
  localparam int WAY_NUM    = 4;
  localparam int WAY_WTH    = 2;
  localparam int SET_NUM    = 16;
  localparam int SET_WTH    = 4;
  // words per line
  localparam int BEATS      = 4;
  localparam int BEAT_WTH   = 2;
  localparam int WORD_BYTES = 8;
  localparam int OFS_WTH    = 3;
  localparam int ADDR_WTH   = 32;
  // what is left above the set index
  localparam int TAG_WTH    = ADDR_WTH - SET_WTH - BEAT_WTH - OFS_WTH;

  // ========================================
  // types
  // ========================================
  typedef logic [WORD_BYTES*8-1:0] word_t;
  typedef logic [WORD_BYTES-1:0]   mask_t;
  typedef logic [TAG_WTH-1:0]      tag_t;
  typedef logic [SET_WTH-1:0]      set_idx_t;
  typedef logic [WAY_WTH-1:0]      way_idx_t;
  typedef logic [BEAT_WTH-1:0]     beat_idx_t;
  // one bit per way, one-hot or flags
  typedef logic [WAY_NUM-1:0]      way_vec_t;

  // address split, msb first
  typedef struct packed {
    tag_t               tag;
    set_idx_t           set_idx;
    beat_idx_t          beat;
    logic [OFS_WTH-1:0] ofs;
  } addr_t;

endpackage

`default_nettype wire

/* rtl/l2_bus_pkg.sv */
// client, burst and way-array payloads
// bursts are always a full line of 4 beats, with the address aligned to the line
// memory returns beats in order and gives no error response
`default_nettype none

package l2_bus_pkg;
  import l2_geom_pkg::*;

  // ========================================
  // client side
  // ========================================
  // one word per request
  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t wdata;
    // byte enables, don't care on reads
    mask_t mask;
  } cache_req_t;

  typedef struct packed {
    // echo of the request's write flag
    logic  we;
    word_t rdata;
  } cache_rsp_t;

  // ========================================
  // memory side
  // ========================================
  // beat and offset bits are always zero
  typedef logic [ADDR_WTH-1:0] mem_addr_t;

  typedef struct packed {
    word_t data;
    logic  last;
  } mem_beat_t;

  // ========================================
  // way arrays
  // ========================================
  // broadcast to all ways, and only the enabled way writes
  typedef struct packed {
    set_idx_t  set_idx;
    beat_idx_t beat;
    word_t     wdata;
    mask_t     mask;
    logic      data_we;
    // tag write also sets valid
    logic      tag_we;
    tag_t      tag;
    logic      dirty;
  } way_cmd_t;

  // state of the commanded set in one way
  typedef struct packed {
    logic  valid;
    logic  dirty;
    tag_t  tag;
    logic  match;
    word_t rdata;
  } way_stat_t;

endpackage

`default_nettype wire

/* rtl/l2_way.sv */
// one way of the cache, with flops for all state and no SRAM macro
// reads are combinational on the set and beat of the command
// a write lands on the clock edge where we_i is high
`default_nettype none
`timescale 1ns/100ps

module l2_way
  import l2_geom_pkg::*;
  import l2_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  way_cmd_t  cmd_i,
  input  logic      we_i,
  input  tag_t      lookup_tag_i,
  output way_stat_t stat_o
);

  // ========================================
  // storage
  // ========================================
  logic [SET_NUM-1:0] valid_q;
  logic [SET_NUM-1:0] dirty_q;
  tag_t               tag_mem  [SET_NUM];
  word_t              data_mem [SET_NUM][BEATS];

  // per-set flags, all lines invalid out of reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (we_i && cmd_i.tag_we) begin
      valid_q[cmd_i.set_idx] <= 1'b1;
      dirty_q[cmd_i.set_idx] <= cmd_i.dirty;
    end
  end

  always_ff @(posedge clk_i) begin
    if (we_i && cmd_i.tag_we) begin
      tag_mem[cmd_i.set_idx] <= cmd_i.tag;
    end
    // byte lanes under the mask only
    if (we_i && cmd_i.data_we) begin
      for (int b = 0; b < WORD_BYTES; b++) begin
        if (cmd_i.mask[b]) begin
          data_mem[cmd_i.set_idx][cmd_i.beat][b*8 +: 8] <= cmd_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // ========================================
  // status
  // ========================================
  assign stat_o.valid = valid_q[cmd_i.set_idx];
  assign stat_o.dirty = dirty_q[cmd_i.set_idx];
  assign stat_o.tag   = tag_mem[cmd_i.set_idx];
  // raw compare, the selector qualifies it with valid
  assign stat_o.match = (tag_mem[cmd_i.set_idx] == lookup_tag_i);
  assign stat_o.rdata = data_mem[cmd_i.set_idx][cmd_i.beat];

endmodule

`default_nettype wire

/* rtl/l2_victim_sel.sv */
// hit detection, true LRU per set and victim choice
// every output is combinational from stat_i and the set's current age order
// LRU changes only on a touch, so the victim stays put while a miss is served
`default_nettype none
`timescale 1ns/100ps

module l2_victim_sel
  import l2_geom_pkg::*;
  import l2_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  set_idx_t  set_i,
  input  way_stat_t stat_i [WAY_NUM],
  input  logic      touch_i,
  input  way_vec_t  touch_way_i,
  output logic      hit_o,
  output way_vec_t  hit_way_o,
  output word_t     hit_word_o,
  output way_vec_t  victim_way_o,
  output logic      victim_dirty_o,
  output tag_t      victim_tag_o,
  output word_t     victim_word_o
);

  // age per way and set, 0 is most recent
  way_idx_t [SET_NUM-1:0][WAY_NUM-1:0] age_q;
  way_vec_t hit_vec;
  way_vec_t oldest_vec;
  way_idx_t touch_idx;

  // ========================================
  // hit and victim
  // ========================================
  always_comb begin
    for (int i = 0; i < WAY_NUM; i++) begin
      hit_vec[i]    = stat_i[i].valid && stat_i[i].match;
      oldest_vec[i] = (age_q[set_i][i] == way_idx_t'(WAY_NUM - 1));
    end
  end

  assign hit_o     = |hit_vec;
  assign hit_way_o = hit_vec;

  // lowest invalid way wins, so scan downward
  // the oldest way is taken when the set is full
  always_comb begin
    victim_way_o = oldest_vec;
    for (int i = WAY_NUM - 1; i >= 0; i--) begin
      if (!stat_i[i].valid) begin
        victim_way_o    = '0;
        victim_way_o[i] = 1'b1;
      end
    end
  end

  // one-hot muxes as and-or
  always_comb begin
    hit_word_o     = '0;
    victim_dirty_o = 1'b0;
    victim_tag_o   = '0;
    victim_word_o  = '0;
    for (int i = 0; i < WAY_NUM; i++) begin
      if (hit_vec[i]) begin
        hit_word_o = hit_word_o | stat_i[i].rdata;
      end
      if (victim_way_o[i]) begin
        victim_dirty_o = victim_dirty_o | (stat_i[i].valid & stat_i[i].dirty);
        victim_tag_o   = victim_tag_o | stat_i[i].tag;
        victim_word_o  = victim_word_o | stat_i[i].rdata;
      end
    end
  end

  // ========================================
  // LRU update
  // ========================================
  always_comb begin
    touch_idx = '0;
    for (int i = 0; i < WAY_NUM; i++) begin
      if (touch_way_i[i]) begin
        touch_idx = way_idx_t'(i);
      end
    end
  end

  // ways younger than the touched one age by one, and the touched way becomes 0
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int s = 0; s < SET_NUM; s++) begin
        for (int w = 0; w < WAY_NUM; w++) begin
          age_q[s][w] <= way_idx_t'(w);
        end
      end
    end else if (touch_i) begin
      for (int w = 0; w < WAY_NUM; w++) begin
        if (touch_way_i[w]) begin
          age_q[set_i][w] <= '0;
        end else if (age_q[set_i][w] < age_q[set_i][touch_idx]) begin
          age_q[set_i][w] <= age_q[set_i][w] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/l2_ctrl_fsm.sv */
// request sequencer, one client request in flight at a time
// a hit responds 2 cycles after the request transfer
// a miss writes back a dirty victim, refills the line and replays the lookup
// the w beat is read live from the arrays and holds because nothing writes meanwhile
`default_nettype none
`timescale 1ns/100ps

module l2_ctrl_fsm
  import l2_geom_pkg::*;
  import l2_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  // client
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  cache_req_t req_i,
  output logic       rsp_valid_o,
  input  logic       rsp_ready_i,
  output cache_rsp_t rsp_o,
  // refill path
  output logic       ar_valid_o,
  input  logic       ar_ready_i,
  output mem_addr_t  ar_addr_o,
  input  logic       r_valid_i,
  output logic       r_ready_o,
  input  mem_beat_t  r_beat_i,
  // write-back path
  output logic       aw_valid_o,
  input  logic       aw_ready_i,
  output mem_addr_t  aw_addr_o,
  output logic       w_valid_o,
  input  logic       w_ready_i,
  output mem_beat_t  w_beat_o,
  input  logic       b_valid_i,
  output logic       b_ready_o,
  // way arrays
  output way_cmd_t   cmd_o,
  output way_vec_t   way_we_o,
  output tag_t       lookup_tag_o,
  // selector
  input  logic       hit_i,
  input  way_vec_t   hit_way_i,
  input  word_t      hit_word_i,
  input  way_vec_t   victim_way_i,
  input  logic       victim_dirty_i,
  input  tag_t       victim_tag_i,
  input  word_t      victim_word_i,
  output logic       touch_o,
  output way_vec_t   touch_way_o
);

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_RESPOND,
    ST_WB_ADDR,
    ST_WB_DATA,
    ST_WB_RESP,
    ST_RF_ADDR,
    ST_RF_DATA,
    ST_REPLAY
  } state_e;

  state_e     state_q, state_d;
  beat_idx_t  beat_q, beat_d;
  cache_req_t req_q;
  cache_rsp_t rsp_q;
  way_vec_t   victim_q;
  tag_t       victim_tag_q;
  word_t      merged_word;
  logic       lookup_hit;
  logic       hit_write;

  // ========================================
  // sequencer
  // ========================================
  always_comb begin
    state_d = state_q;
    beat_d  = beat_q;
    unique case (state_q)
      ST_IDLE: begin
        if (req_valid_i) begin
          state_d = ST_LOOKUP;
        end
      end
      // status of all ways is valid in this cycle
      ST_LOOKUP: begin
        if (hit_i) begin
          state_d = ST_RESPOND;
        end else if (victim_dirty_i) begin
          state_d = ST_WB_ADDR;
        end else begin
          state_d = ST_RF_ADDR;
        end
      end
      ST_RESPOND: begin
        if (rsp_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      ST_WB_ADDR: begin
        if (aw_ready_i) begin
          state_d = ST_WB_DATA;
          beat_d  = '0;
        end
      end
      // beat index moves only on a w transfer
      ST_WB_DATA: begin
        if (w_ready_i) begin
          beat_d = beat_q + 1'b1;
          if (w_beat_o.last) begin
            state_d = ST_WB_RESP;
          end
        end
      end
      ST_WB_RESP: begin
        if (b_valid_i) begin
          state_d = ST_RF_ADDR;
        end
      end
      ST_RF_ADDR: begin
        if (ar_ready_i) begin
          state_d = ST_RF_DATA;
          beat_d  = '0;
        end
      end
      ST_RF_DATA: begin
        if (r_valid_i) begin
          beat_d = beat_q + 1'b1;
          if (r_beat_i.last) begin
            state_d = ST_REPLAY;
          end
        end
      end
      // one spare cycle, then look up again with the refilled line
      ST_REPLAY: begin
        state_d = ST_LOOKUP;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      beat_q  <= '0;
    end else begin
      state_q <= state_d;
      beat_q  <= beat_d;
    end
  end

  // ========================================
  // request, response and victim
  // ========================================
  assign lookup_hit = (state_q == ST_LOOKUP) && hit_i;
  assign hit_write  = lookup_hit && req_q.we;

  // new bytes over the old word
  always_comb begin
    merged_word = hit_word_i;
    for (int b = 0; b < WORD_BYTES; b++) begin
      if (req_q.mask[b]) begin
        merged_word[b*8 +: 8] = req_q.wdata[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      req_q <= req_i;
    end
    if (lookup_hit) begin
      rsp_q.we    <= req_q.we;
      rsp_q.rdata <= req_q.we ? merged_word : hit_word_i;
    end
    // the victim is latched so that the refill cannot move it
    if ((state_q == ST_LOOKUP) && !hit_i) begin
      victim_q     <= victim_way_i;
      victim_tag_q <= victim_tag_i;
    end
  end

  // ========================================
  // handshakes
  // ========================================
  assign req_ready_o = (state_q == ST_IDLE);
  assign rsp_valid_o = (state_q == ST_RESPOND);
  assign rsp_o       = rsp_q;
  assign aw_valid_o  = (state_q == ST_WB_ADDR);
  assign w_valid_o   = (state_q == ST_WB_DATA);
  assign b_ready_o   = (state_q == ST_WB_RESP);
  assign ar_valid_o  = (state_q == ST_RF_ADDR);
  assign r_ready_o   = (state_q == ST_RF_DATA);

  // line-aligned burst addresses
  assign aw_addr_o = {victim_tag_q, req_q.addr.set_idx, {(BEAT_WTH + OFS_WTH){1'b0}}};
  assign ar_addr_o = {req_q.addr.tag, req_q.addr.set_idx, {(BEAT_WTH + OFS_WTH){1'b0}}};

  assign w_beat_o.data = victim_word_i;
  assign w_beat_o.last = (beat_q == beat_idx_t'(BEATS - 1));

  // ========================================
  // way command
  // ========================================
  assign lookup_tag_o = req_q.addr.tag;
  assign touch_o      = lookup_hit;
  assign touch_way_o  = hit_way_i;

  // a write hit merges and marks dirty, and a refill beat writes the whole word clean
  always_comb begin
    cmd_o.set_idx = req_q.addr.set_idx;
    cmd_o.beat    = req_q.addr.beat;
    cmd_o.wdata   = req_q.wdata;
    cmd_o.mask    = req_q.mask;
    cmd_o.tag     = req_q.addr.tag;
    cmd_o.dirty   = 1'b1;
    cmd_o.data_we = hit_write;
    cmd_o.tag_we  = hit_write;
    way_we_o      = hit_write ? hit_way_i : '0;
    if ((state_q == ST_WB_DATA) || (state_q == ST_RF_DATA)) begin
      cmd_o.beat = beat_q;
    end
    if (state_q == ST_RF_DATA) begin
      cmd_o.wdata   = r_beat_i.data;
      cmd_o.mask    = '1;
      cmd_o.dirty   = 1'b0;
      cmd_o.data_we = r_valid_i;
      cmd_o.tag_we  = r_valid_i;
      way_we_o      = r_valid_i ? victim_q : '0;
    end
  end

endmodule

`default_nettype wire

/* rtl/l2_cache_top.sv */
// 4-way write-back L2 with a one-word client port and line bursts to memory
// a single outstanding request, so req_ready_o drops until the response is taken
// memory must return exactly 4 r beats, with last on the fourth
`default_nettype none
`timescale 1ns/100ps

module l2_cache_top
  import l2_geom_pkg::*;
  import l2_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  // client
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  cache_req_t req_i,
  output logic       rsp_valid_o,
  input  logic       rsp_ready_i,
  output cache_rsp_t rsp_o,
  // memory read
  output logic       ar_valid_o,
  input  logic       ar_ready_i,
  output mem_addr_t  ar_addr_o,
  input  logic       r_valid_i,
  output logic       r_ready_o,
  input  mem_beat_t  r_beat_i,
  // memory write
  output logic       aw_valid_o,
  input  logic       aw_ready_i,
  output mem_addr_t  aw_addr_o,
  output logic       w_valid_o,
  input  logic       w_ready_i,
  output mem_beat_t  w_beat_o,
  input  logic       b_valid_i,
  output logic       b_ready_o
);

  way_cmd_t  way_cmd;
  way_vec_t  way_we;
  tag_t      lookup_tag;
  way_stat_t way_stat [WAY_NUM];
  logic      hit;
  way_vec_t  hit_way;
  word_t     hit_word;
  way_vec_t  victim_way;
  logic      victim_dirty;
  tag_t      victim_tag;
  word_t     victim_word;
  logic      touch;
  way_vec_t  touch_way;

  // ========================================
  // control
  // ========================================
  l2_ctrl_fsm u_ctrl (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_i          (req_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_o          (rsp_o),
    .ar_valid_o     (ar_valid_o),
    .ar_ready_i     (ar_ready_i),
    .ar_addr_o      (ar_addr_o),
    .r_valid_i      (r_valid_i),
    .r_ready_o      (r_ready_o),
    .r_beat_i       (r_beat_i),
    .aw_valid_o     (aw_valid_o),
    .aw_ready_i     (aw_ready_i),
    .aw_addr_o      (aw_addr_o),
    .w_valid_o      (w_valid_o),
    .w_ready_i      (w_ready_i),
    .w_beat_o       (w_beat_o),
    .b_valid_i      (b_valid_i),
    .b_ready_o      (b_ready_o),
    .cmd_o          (way_cmd),
    .way_we_o       (way_we),
    .lookup_tag_o   (lookup_tag),
    .hit_i          (hit),
    .hit_way_i      (hit_way),
    .hit_word_i     (hit_word),
    .victim_way_i   (victim_way),
    .victim_dirty_i (victim_dirty),
    .victim_tag_i   (victim_tag),
    .victim_word_i  (victim_word),
    .touch_o        (touch),
    .touch_way_o    (touch_way)
  );

  // ========================================
  // ways
  // ========================================
  for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
    l2_way u_way (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .cmd_i        (way_cmd),
      .we_i         (way_we[w]),
      .lookup_tag_i (lookup_tag),
      .stat_o       (way_stat[w])
    );
  end

  // replacement, on the set of the current command
  l2_victim_sel u_victim_sel (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .set_i          (way_cmd.set_idx),
    .stat_i         (way_stat),
    .touch_i        (touch),
    .touch_way_i    (touch_way),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .hit_word_o     (hit_word),
    .victim_way_o   (victim_way),
    .victim_dirty_o (victim_dirty),
    .victim_tag_o   (victim_tag),
    .victim_word_o  (victim_word)
  );

endmodule

`default_nettype wire

/* bench/l2_mem_model.sv */
// burst memory slave for the cache, one read and one write burst at a time
// unwritten words read as {~word address, word address}
// ready and r valid stall at random, r valid holds until taken
`default_nettype none
`timescale 1ns/100ps

module l2_mem_model
  import l2_geom_pkg::*;
  import l2_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      ar_valid_i,
  output logic      ar_ready_o,
  input  mem_addr_t ar_addr_i,
  output logic      r_valid_o,
  input  logic      r_ready_i,
  output mem_beat_t r_beat_o,
  input  logic      aw_valid_i,
  output logic      aw_ready_o,
  input  mem_addr_t aw_addr_i,
  input  logic      w_valid_i,
  output logic      w_ready_o,
  input  mem_beat_t w_beat_i,
  output logic      b_valid_o,
  input  logic      b_ready_i,
  // transfers seen on this edge, for the bench monitors
  output logic      ar_seen_o,
  output logic      aw_seen_o,
  output logic      w_seen_o
);

  word_t      mem [int];
  int         seed = 32'ha457;
  logic       rd_busy;
  mem_addr_t  rd_addr;
  int         rd_cnt;
  logic [1:0] wr_phase;
  mem_addr_t  wr_addr;
  int         wr_cnt;

  assign ar_seen_o = ar_valid_i && ar_ready_o;
  assign aw_seen_o = aw_valid_i && aw_ready_o;
  assign w_seen_o  = w_valid_i && w_ready_o;

  function automatic word_t read_word(input int wa);
    logic [31:0] v;
    v = wa;
    if (mem.exists(wa)) begin
      return mem[wa];
    end
    return {~v, v};
  endfunction

  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_beat_o   = '0;
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    b_valid_o  = 1'b0;
    rd_busy    = 1'b0;
    wr_phase   = 2'd0;
  end

  // ========================================
  // one step per clock
  // ========================================
  always @(posedge clk_i) begin : step
    logic r_hold;
    r_hold = r_valid_o && !r_ready_i;
    if (!arst_n_i) begin
      rd_busy  = 1'b0;
      wr_phase = 2'd0;
      r_hold   = 1'b0;
    end else begin
      if (ar_valid_i && ar_ready_o) begin
        rd_busy = 1'b1;
        rd_addr = ar_addr_i;
        rd_cnt  = 0;
      end
      if (r_valid_o && r_ready_i) begin
        rd_cnt++;
        if (rd_cnt == BEATS) rd_busy = 1'b0;
      end
      if (aw_valid_i && aw_ready_o) begin
        wr_phase = 2'd1;
        wr_addr  = aw_addr_i;
        wr_cnt   = 0;
      end
      if (w_valid_i && w_ready_o) begin
        mem[int'(wr_addr >> OFS_WTH) + wr_cnt] = w_beat_i.data;
        wr_cnt++;
        if (w_beat_i.last) wr_phase = 2'd2;
      end
      if (b_valid_o && b_ready_i) wr_phase = 2'd0;
    end
    #1;
    ar_ready_o = arst_n_i && !rd_busy && (($random(seed) & 3) != 0);
    r_valid_o  = rd_busy && (r_hold || (($random(seed) & 3) != 0));
    r_beat_o.data = rd_busy ? read_word(int'(rd_addr >> OFS_WTH) + rd_cnt) : '0;
    r_beat_o.last = rd_busy && (rd_cnt == BEATS - 1);
    aw_ready_o = arst_n_i && (wr_phase == 2'd0) && (($random(seed) & 3) != 0);
    w_ready_o  = (wr_phase == 2'd1) && (($random(seed) & 3) != 0);
    b_valid_o  = (wr_phase == 2'd2);
  end

endmodule

`default_nettype wire

/* bench/l2_cache_chk.sv */
// protocol checks on the cache ports, bound into the top level
// only active out of reset
`default_nettype none
`timescale 1ns/100ps

module l2_cache_chk
  import l2_geom_pkg::*;
  import l2_bus_pkg::*;
(
  input logic       clk_i,
  input logic       arst_n_i,
  input logic       aw_valid_i,
  input logic       aw_ready_i,
  input mem_addr_t  aw_addr_i,
  input logic       w_valid_i,
  input logic       w_ready_i,
  input mem_beat_t  w_beat_i,
  input logic       req_ready_i,
  input logic       rsp_valid_i,
  input logic       rsp_ready_i,
  input cache_rsp_t rsp_i
);

  // write-back payloads hold while stalled
  a_aw_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_addr_i))
    else $error("aw payload moved while stalled");

  a_w_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_beat_i))
    else $error("w payload moved while stalled");

  a_rsp_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
    else $error("response moved before it was taken");

  // single request in flight
  a_one_req : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(req_ready_i && rsp_valid_i))
    else $error("request accepted while a response is pending");

endmodule

bind l2_cache_top l2_cache_chk u_chk (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .aw_valid_i  (aw_valid_o),
  .aw_ready_i  (aw_ready_i),
  .aw_addr_i   (aw_addr_o),
  .w_valid_i   (w_valid_o),
  .w_ready_i   (w_ready_i),
  .w_beat_i    (w_beat_o),
  .req_ready_i (req_ready_o),
  .rsp_valid_i (rsp_valid_o),
  .rsp_ready_i (rsp_ready_i),
  .rsp_i       (rsp_o)
);

`default_nettype wire

/* bench/l2_cache_tb.sv */
// testbench for the L2 cache, with a reference model of arrays, LRU and memory
// stops at the first mismatch, run length bounded by a cycle limit
`default_nettype none
`timescale 1ns/100ps

module l2_cache_tb
  import l2_geom_pkg::*;
  import l2_bus_pkg::*;
;
  localparam int TIMEOUT = 20000;

  logic clk = 1'b0;
  logic arst_n, req_valid, req_ready, rsp_valid, rsp_ready;
  logic ar_valid, ar_ready, r_valid, r_ready, aw_valid, aw_ready;
  logic w_valid, w_ready, b_valid, b_ready, ar_seen, aw_seen, w_seen;
  cache_req_t req;
  cache_rsp_t rsp;
  mem_addr_t  ar_addr, aw_addr;
  mem_beat_t  r_beat, w_beat;

  int seed = 32'ha457;
  int rdy_seed = 32'ha457;
  int cyc = 0;
  int req_cyc, first_cyc, done_cnt = 0;
  logic stall_rsp, rsp_seen = 1'b0, exp_hit;

  // reference state
  logic  ref_valid [SET_NUM][WAY_NUM];
  logic  ref_dirty [SET_NUM][WAY_NUM];
  tag_t  ref_tag   [SET_NUM][WAY_NUM];
  word_t ref_data  [SET_NUM][WAY_NUM][BEATS];
  int    ref_age   [SET_NUM][WAY_NUM];
  word_t ref_mem   [int];
  cache_rsp_t exp_rsp_q [$];
  mem_addr_t  exp_ar_q [$];
  mem_addr_t  exp_aw_q [$];
  mem_beat_t  exp_w_q [$];

  always #5 clk = ~clk;

  l2_cache_top dut (
    .clk_i(clk), .arst_n_i(arst_n),
    .req_valid_i(req_valid), .req_ready_o(req_ready), .req_i(req),
    .rsp_valid_o(rsp_valid), .rsp_ready_i(rsp_ready), .rsp_o(rsp),
    .ar_valid_o(ar_valid), .ar_ready_i(ar_ready), .ar_addr_o(ar_addr),
    .r_valid_i(r_valid), .r_ready_o(r_ready), .r_beat_i(r_beat),
    .aw_valid_o(aw_valid), .aw_ready_i(aw_ready), .aw_addr_o(aw_addr),
    .w_valid_o(w_valid), .w_ready_i(w_ready), .w_beat_o(w_beat),
    .b_valid_i(b_valid), .b_ready_o(b_ready)
  );

  l2_mem_model u_mem (
    .clk_i(clk), .arst_n_i(arst_n),
    .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_addr_i(ar_addr),
    .r_valid_o(r_valid), .r_ready_i(r_ready), .r_beat_o(r_beat),
    .aw_valid_i(aw_valid), .aw_ready_o(aw_ready), .aw_addr_i(aw_addr),
    .w_valid_i(w_valid), .w_ready_o(w_ready), .w_beat_i(w_beat),
    .b_valid_o(b_valid), .b_ready_i(b_ready),
    .ar_seen_o(ar_seen), .aw_seen_o(aw_seen), .w_seen_o(w_seen)
  );

  // ========================================
  // failure and compare tasks
  // ========================================
  task automatic stop_fail(input string why);
    if (why != "") $display("%s", why);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got %h exp %h", name, got, exp);
      stop_fail("");
    end
  endtask

  task automatic check_rsp(input cache_rsp_t got, input cache_rsp_t exp);
    if (got !== exp) begin
      $display("ERR rsp_o got %h exp %h", got, exp);
      stop_fail("");
    end
  endtask

  task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h exp %h", name, got, exp);
      stop_fail("");
    end
  endtask

  task automatic check_beat(input mem_beat_t got, input mem_beat_t exp);
    if (got !== exp) begin
      $display("ERR w_beat_o got %h exp %h", got, exp);
      stop_fail("");
    end
  endtask

  // ========================================
  // reference model
  // ========================================
  function automatic word_t ref_read(input int wa);
    logic [31:0] v;
    v = wa;
    if (ref_mem.exists(wa)) return ref_mem[wa];
    return {~v, v};
  endfunction

  // one request against the model, queues the bursts it implies
  function automatic cache_rsp_t ref_access(input cache_req_t r, output logic hit);
    cache_rsp_t e;
    mem_addr_t  la;
    mem_beat_t  bt;
    int s, w, t;
    s = r.addr.set_idx;
    w = -1;
    for (int v = 0; v < WAY_NUM; v++) begin
      if (ref_valid[s][v] && ref_tag[s][v] == r.addr.tag) w = v;
    end
    hit = (w >= 0);
    if (!hit) begin
      for (int v = WAY_NUM - 1; v >= 0; v--) begin
        if (!ref_valid[s][v]) w = v;
      end
      if (w < 0) begin
        for (int v = 0; v < WAY_NUM; v++) begin
          if (ref_age[s][v] == WAY_NUM - 1) w = v;
        end
      end
      // dirty victim goes back first
      if (ref_valid[s][w] && ref_dirty[s][w]) begin
        la = {ref_tag[s][w], set_idx_t'(s), {(BEAT_WTH + OFS_WTH){1'b0}}};
        exp_aw_q.push_back(la);
        for (int b = 0; b < BEATS; b++) begin
          bt.data = ref_data[s][w][b];
          bt.last = (b == BEATS - 1);
          exp_w_q.push_back(bt);
          ref_mem[int'(la >> OFS_WTH) + b] = bt.data;
        end
      end
      la = {r.addr.tag, r.addr.set_idx, {(BEAT_WTH + OFS_WTH){1'b0}}};
      exp_ar_q.push_back(la);
      for (int b = 0; b < BEATS; b++) begin
        ref_data[s][w][b] = ref_read(int'(la >> OFS_WTH) + b);
      end
      ref_valid[s][w] = 1'b1;
      ref_dirty[s][w] = 1'b0;
      ref_tag[s][w]   = r.addr.tag;
    end
    // true LRU, younger ways age by one
    t = ref_age[s][w];
    for (int v = 0; v < WAY_NUM; v++) begin
      if (v == w) ref_age[s][v] = 0;
      else if (ref_age[s][v] < t) ref_age[s][v]++;
    end
    if (r.we) begin
      for (int b = 0; b < WORD_BYTES; b++) begin
        if (r.mask[b]) ref_data[s][w][r.addr.beat][b*8 +: 8] = r.wdata[b*8 +: 8];
      end
      ref_dirty[s][w] = 1'b1;
    end
    e.we    = r.we;
    e.rdata = ref_data[s][w][r.addr.beat];
    return e;
  endfunction

  function automatic addr_t make_addr(input int tag, input int set, input int beat);
    addr_t a;
    a.tag     = tag_t'(tag);
    a.set_idx = set_idx_t'(set);
    a.beat    = beat_idx_t'(beat);
    a.ofs     = '0;
    return a;
  endfunction

  // ========================================
  // stimulus
  // ========================================
  task automatic send(input logic we, input addr_t a, input word_t d, input mask_t m);
    cache_req_t r;
    logic       h;
    int         start;
    r.we    = we;
    r.addr  = a;
    r.wdata = d;
    r.mask  = m;
    @(posedge clk);
    #1;
    req_valid = 1'b1;
    req       = r;
    while (!req_ready) begin
      @(posedge clk);
      #1;
    end
    // transfer on this edge
    @(posedge clk);
    req_cyc = cyc;
    start   = done_cnt;
    exp_rsp_q.push_back(ref_access(r, h));
    exp_hit = h;
    #1 req_valid = 1'b0;
    wait (done_cnt != start);
    if (exp_ar_q.size() || exp_aw_q.size() || exp_w_q.size()) begin
      stop_fail("expected memory burst did not happen");
    end
  endtask

  always @(posedge clk) begin
    #1;
    rsp_ready = stall_rsp ? 1'($random(rdy_seed)) : 1'b1;
  end

  // ========================================
  // compare and timeout
  // ========================================
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT) stop_fail("timeout, the run passed its cycle limit");
    if (arst_n) begin
      if (rsp_valid && !rsp_seen) begin
        rsp_seen  = 1'b1;
        first_cyc = cyc;
      end
      if (rsp_valid && rsp_ready) begin
        if (exp_rsp_q.size() == 0) stop_fail("response without a request");
        else check_rsp(rsp, exp_rsp_q.pop_front());
        if (exp_hit && (first_cyc - req_cyc != 2)) stop_fail("hit response not 2 cycles late");
        rsp_seen = 1'b0;
        done_cnt++;
      end
      if (ar_seen) begin
        if (exp_ar_q.size() == 0) stop_fail("unexpected refill burst");
        else check_addr("ar_addr_o", ar_addr, exp_ar_q.pop_front());
      end
      if (aw_seen) begin
        if (exp_aw_q.size() == 0) stop_fail("unexpected write-back burst");
        else check_addr("aw_addr_o", aw_addr, exp_aw_q.pop_front());
      end
      if (w_seen) begin
        if (exp_w_q.size() == 0) stop_fail("unexpected write-back beat");
        else check_beat(w_beat, exp_w_q.pop_front());
      end
    end
  end

  initial begin
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b1;
    stall_rsp = 1'b0;
    for (int s = 0; s < SET_NUM; s++) begin
      for (int w = 0; w < WAY_NUM; w++) begin
        ref_valid[s][w] = 1'b0;
        ref_dirty[s][w] = 1'b0;
        ref_age[s][w]   = w;
      end
    end
    repeat (5) @(posedge clk);
    #1 arst_n = 1'b1;
    // idle outputs out of reset
    check_bit("req_ready_o", req_ready, 1'b1);
    check_bit("rsp_valid_o", rsp_valid, 1'b0);
    check_bit("ar_valid_o", ar_valid, 1'b0);
    check_bit("aw_valid_o", aw_valid, 1'b0);
    check_bit("w_valid_o", w_valid, 1'b0);
    check_bit("r_ready_o", r_ready, 1'b0);
    check_bit("b_ready_o", b_ready, 1'b0);
    // cold read, then a hit in the same line
    send(1'b0, make_addr(5, 1, 0), '0, '0);
    send(1'b0, make_addr(5, 1, 2), '0, '0);
    // masked write merge
    send(1'b1, make_addr(5, 1, 2), 64'h0123_4567_89ab_cdef, 8'h3c);
    send(1'b0, make_addr(5, 1, 2), '0, '0);
    // seven tags in set 2, mixed dirty and clean victims
    // a re-read of the first line once the set is full tells LRU from FIFO
    for (int t = 0; t < 7; t++) begin
      if (t == 4) begin
        send(1'b0, make_addr(8, 2, 1), '0, '0);
      end
      send(t % 3 != 1, make_addr(t + 8, 2, t % BEATS), {2{32'(t) ^ 32'h5a5a_0f0f}}, 8'hff);
    end
    // random traffic over three sets with stalls everywhere
    stall_rsp = 1'b1;
    repeat (400) begin
      send(1'($random(seed)), make_addr($unsigned($random(seed)) % 6,
           $unsigned($random(seed)) % 3, $unsigned($random(seed)) % BEATS),
           {$random(seed), $random(seed)}, mask_t'($random(seed)));
    end
    // back in idle with nothing left on the memory ports
    @(posedge clk);
    if (!(req_ready === 1'b1 && rsp_valid === 1'b0 && ar_valid === 1'b0
          && aw_valid === 1'b0 && w_valid === 1'b0)) begin
      stop_fail("cache not idle at the end of the run");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* sources.f */
rtl/l2_geom_pkg.sv
rtl/l2_bus_pkg.sv
rtl/l2_way.sv
rtl/l2_victim_sel.sv
rtl/l2_ctrl_fsm.sv
rtl/l2_cache_top.sv
bench/l2_mem_model.sv
bench/l2_cache_chk.sv
bench/l2_cache_tb.sv

/* Bender.yml */
package:
  name: l2_cache

sources:
  - rtl/l2_geom_pkg.sv
  - rtl/l2_bus_pkg.sv
  - rtl/l2_way.sv
  - rtl/l2_victim_sel.sv
  - rtl/l2_ctrl_fsm.sv
  - rtl/l2_cache_top.sv
  - target: test
    files:
      - bench/l2_mem_model.sv
      - bench/l2_cache_chk.sv
      - bench/l2_cache_tb.sv
